// File: common/elink_rx_pkg.sv
// Shared sizes for the E-link receiver
// APB register map, K28.5 comma codes, FIFO depth and lock threshold
`default_nettype none

package elink_rx_pkg;

  // Datapath widths
  localparam int sym_w  = 10;              // Encoded 8b10b symbol
  localparam int byte_w = 8;               // Decoded byte
  localparam int word_w = byte_w + 1;      // Byte plus K flag

  // Receive FIFO
  localparam int fifo_depth = 16;
  localparam int level_w    = 5;           // Counts 0..fifo_depth

  // K28.5 in transmission order, bit 9 is bit a (sent first)
  localparam logic [sym_w-1:0] comma_pos = 10'b1100000101;  // RD+ form
  localparam logic [sym_w-1:0] comma_neg = 10'b0011111010;  // RD- form

  // APB slave
  localparam int apb_aw = 4;
  localparam int apb_dw = 32;
  localparam logic [apb_aw-1:0] addr_ctrl   = 4'h0;
  localparam logic [apb_aw-1:0] addr_status = 4'h4;
  localparam logic [apb_aw-1:0] addr_data   = 4'h8;

  // Commas at one phase before the word boundary is trusted
  localparam int lock_commas = 2;

endpackage

`default_nettype wire

// File: elink_rx/elink_rx_ctrl.sv
// APB slave for the E-link receiver
// CTRL register, STATUS with sticky error bits, DATA pop from the FIFO
`timescale 1ns/1ps
`default_nettype none

module elink_rx_ctrl (
  input  wire                               bit_clk,
  input  wire                               reset,
  input  wire                               psel,
  input  wire                               penable,
  input  wire                               pwrite,
  input  wire [elink_rx_pkg::apb_aw-1:0]    paddr,
  input  wire [elink_rx_pkg::apb_dw-1:0]    pwdata,
  input  wire                               aligned,
  input  wire                               empty,
  input  wire [elink_rx_pkg::level_w-1:0]   level,
  input  wire [elink_rx_pkg::word_w-1:0]    rd_data,
  input  wire                               code_err,
  input  wire                               overflow,
  output logic [elink_rx_pkg::apb_dw-1:0]   prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              enable,
  output logic                              swap_bits,
  output logic                              rd_en
);

  logic access;         // Second cycle of a transfer
  logic wr_acc;
  logic rd_acc;
  logic sel_ctrl;
  logic sel_status;
  logic sel_data;
  logic err_sticky;     // Some symbol failed decode
  logic ovf_sticky;     // Some word was dropped

  assign access     = psel && penable;
  assign wr_acc     = access && pwrite;
  assign rd_acc     = access && !pwrite;
  assign sel_ctrl   = (paddr == elink_rx_pkg::addr_ctrl);
  assign sel_status = (paddr == elink_rx_pkg::addr_status);
  assign sel_data   = (paddr == elink_rx_pkg::addr_data);

  assign pready = 1'b1;  // No wait states

  // Pop the head in the access cycle, only if there is one
  assign rd_en = rd_acc && sel_data && !empty;

  // DATA is read-only and must not be read empty; unmapped offsets fault too
  assign pslverr = access && ((sel_data && (pwrite || empty)) ||
                              !(sel_ctrl || sel_status || sel_data));

  always_ff @(posedge bit_clk) begin
    if (reset) begin
      enable     <= 1'b0;
      swap_bits  <= 1'b0;
      err_sticky <= 1'b0;
      ovf_sticky <= 1'b0;
    end else begin
      if (wr_acc && sel_ctrl) begin
        enable    <= pwdata[0];
        swap_bits <= pwdata[1];
      end
      // New events win over a clear in the same cycle
      if (code_err)
        err_sticky <= 1'b1;
      else if (wr_acc && sel_status && pwdata[2])
        err_sticky <= 1'b0;
      if (overflow)
        ovf_sticky <= 1'b1;
      else if (wr_acc && sel_status && pwdata[3])
        ovf_sticky <= 1'b0;
    end
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (sel_ctrl) begin
      prdata[0] = enable;
      prdata[1] = swap_bits;
    end else if (sel_status) begin
      prdata[0] = aligned;
      prdata[1] = empty;
      prdata[2] = err_sticky;
      prdata[3] = ovf_sticky;
      prdata[8 +: elink_rx_pkg::level_w] = level;   // Bits 12:8
    end else if (sel_data && !empty) begin
      prdata[elink_rx_pkg::word_w-1:0] = rd_data;   // K flag in bit 8
    end
  end

endmodule

`default_nettype wire

// File: elink_rx/elink_deserializer.sv
// Bit-pair deserializer
// Optional pair swap, 11-bit history, two candidate symbol windows
`timescale 1ns/1ps
`default_nettype none

module elink_deserializer (
  input  wire                              bit_clk,
  input  wire                              reset,
  input  wire [1:0]                        rx_bits,
  input  wire                              swap_bits,
  output logic [elink_rx_pkg::sym_w-1:0]   win_a,
  output logic [elink_rx_pkg::sym_w-1:0]   win_b
);

  logic [1:0]                    pair;   // Bit 1 is the earlier bit
  logic [elink_rx_pkg::sym_w:0]  hist;   // Bit 0 is the newest bit

  // Swapped link delivers the earlier bit on rx_bits[0]
  assign pair = swap_bits ? {rx_bits[0], rx_bits[1]} : rx_bits;

  always_ff @(posedge bit_clk) begin
    if (reset)
      hist <= '0;
    else
      hist <= {hist[elink_rx_pkg::sym_w-2:0], pair};  // Older bits move up
  end

  // Oldest bit lands in bit 9, i.e. transmission order
  assign win_a = hist[elink_rx_pkg::sym_w-1:0];  // Ends at newest bit
  assign win_b = hist[elink_rx_pkg::sym_w:1];    // Ends one bit earlier

endmodule

`default_nettype wire

// File: elink_rx/comma_aligner.sv
// Comma aligner
// K28.5 search on two windows, phase lock, one symbol strobe per five cycles
`timescale 1ns/1ps
`default_nettype none

module comma_aligner (
  input  wire                              bit_clk,
  input  wire                              reset,
  input  wire                              enable,
  input  wire [elink_rx_pkg::sym_w-1:0]    win_a,
  input  wire [elink_rx_pkg::sym_w-1:0]    win_b,
  output logic [elink_rx_pkg::sym_w-1:0]   sym,
  output logic                             sym_valid,
  output logic                             sym_comma,
  output logic                             aligned
);

  logic                            sel_b;       // Phase uses win_b
  logic                            have_phase;  // Candidate boundary known
  logic [2:0]                      cnt;         // Cycles since boundary, mod 5
  logic [2:0]                      comma_cnt;   // Commas seen at this phase
  logic [elink_rx_pkg::sym_w-1:0]  win_sel;
  logic                            hit_a;
  logic                            hit_b;
  logic                            boundary;    // Selected window is a full word
  logic                            expected;    // Comma right where it belongs
  logic                            stray;       // Comma anywhere else

  assign hit_a = (win_a == elink_rx_pkg::comma_pos) || (win_a == elink_rx_pkg::comma_neg);
  assign hit_b = (win_b == elink_rx_pkg::comma_pos) || (win_b == elink_rx_pkg::comma_neg);

  assign win_sel  = sel_b ? win_b : win_a;
  assign boundary = have_phase && (cnt == 3'd4);
  assign expected = boundary && (sel_b ? hit_b : hit_a);
  assign stray    = (hit_a || hit_b) && !expected;

  always_ff @(posedge bit_clk) begin
    if (reset || !enable) begin  // Disabled means idle and unlocked
      sel_b      <= 1'b0;
      have_phase <= 1'b0;
      cnt        <= 3'd0;
      comma_cnt  <= 3'd0;
      aligned    <= 1'b0;
      sym_valid  <= 1'b0;
    end else begin
      sym_valid <= 1'b0;
      if (stray) begin
        // Restart search at the new phase, this comma counts as the first
        sel_b      <= !hit_a;
        have_phase <= 1'b1;
        cnt        <= 3'd0;
        comma_cnt  <= 3'd1;
        aligned    <= 1'b0;
      end else if (have_phase) begin
        cnt <= boundary ? 3'd0 : cnt + 3'd1;
        if (expected && !aligned) begin
          comma_cnt <= comma_cnt + 3'd1;
          if (int'(comma_cnt) + 1 >= elink_rx_pkg::lock_commas)
            aligned <= 1'b1;
        end
        if (boundary && aligned)
          sym_valid <= 1'b1;  // Locked, hand the word on
      end
    end
  end

  // Symbol register
  always_ff @(posedge bit_clk) begin
    if (boundary) begin
      sym       <= win_sel;
      sym_comma <= expected;  // Idle comma, decoder drops it
    end
  end

endmodule

`default_nettype wire

// File: elink_rx/dec_8b10b.sv
// 8b10b decoder
// 6b/4b lookup tables, K28.x flag, code error on unknown sub-blocks
`timescale 1ns/1ps
`default_nettype none

module dec_8b10b (
  input  wire                              bit_clk,
  input  wire                              reset,
  input  wire [elink_rx_pkg::sym_w-1:0]    sym,
  input  wire                              sym_valid,
  input  wire                              sym_comma,
  output logic                             wr_en,
  output logic [elink_rx_pkg::word_w-1:0]  wr_data,
  output logic                             code_err
);

  // abcdei to {valid, EDCBA}, both disparities
  function automatic logic [5:0] dec6(input logic [5:0] c);
    case (c)
      6'b100111, 6'b011000: dec6 = {1'b1, 5'd0};
      6'b011101, 6'b100010: dec6 = {1'b1, 5'd1};
      6'b101101, 6'b010010: dec6 = {1'b1, 5'd2};
      6'b110001:            dec6 = {1'b1, 5'd3};
      6'b110101, 6'b001010: dec6 = {1'b1, 5'd4};
      6'b101001:            dec6 = {1'b1, 5'd5};
      6'b011001:            dec6 = {1'b1, 5'd6};
      6'b111000, 6'b000111: dec6 = {1'b1, 5'd7};
      6'b111001, 6'b000110: dec6 = {1'b1, 5'd8};
      6'b100101:            dec6 = {1'b1, 5'd9};
      6'b010101:            dec6 = {1'b1, 5'd10};
      6'b110100:            dec6 = {1'b1, 5'd11};
      6'b001101:            dec6 = {1'b1, 5'd12};
      6'b101100:            dec6 = {1'b1, 5'd13};
      6'b011100:            dec6 = {1'b1, 5'd14};
      6'b010111, 6'b101000: dec6 = {1'b1, 5'd15};
      6'b011011, 6'b100100: dec6 = {1'b1, 5'd16};
      6'b100011:            dec6 = {1'b1, 5'd17};
      6'b010011:            dec6 = {1'b1, 5'd18};
      6'b110010:            dec6 = {1'b1, 5'd19};
      6'b001011:            dec6 = {1'b1, 5'd20};
      6'b101010:            dec6 = {1'b1, 5'd21};
      6'b011010:            dec6 = {1'b1, 5'd22};
      6'b111010, 6'b000101: dec6 = {1'b1, 5'd23};
      6'b110011, 6'b001100: dec6 = {1'b1, 5'd24};
      6'b100110:            dec6 = {1'b1, 5'd25};
      6'b010110:            dec6 = {1'b1, 5'd26};
      6'b110110, 6'b001001: dec6 = {1'b1, 5'd27};
      6'b001110:            dec6 = {1'b1, 5'd28};
      6'b101110, 6'b010001: dec6 = {1'b1, 5'd29};
      6'b011110, 6'b100001: dec6 = {1'b1, 5'd30};
      6'b101011, 6'b010100: dec6 = {1'b1, 5'd31};
      6'b001111, 6'b110000: dec6 = {1'b1, 5'd28};  // K28
      default:              dec6 = 6'b0;
    endcase
  endfunction

  // fghj to {valid, HGF}; 0000 and 1111 never occur
  function automatic logic [3:0] dec4(input logic [3:0] c);
    case (c)
      4'b1011, 4'b0100:                   dec4 = {1'b1, 3'd0};
      4'b1001:                            dec4 = {1'b1, 3'd1};
      4'b0101:                            dec4 = {1'b1, 3'd2};
      4'b1100, 4'b0011:                   dec4 = {1'b1, 3'd3};
      4'b1101, 4'b0010:                   dec4 = {1'b1, 3'd4};
      4'b1010:                            dec4 = {1'b1, 3'd5};
      4'b0110:                            dec4 = {1'b1, 3'd6};
      4'b1110, 4'b0001, 4'b0111, 4'b1000: dec4 = {1'b1, 3'd7};
      default:                            dec4 = 4'b0;
    endcase
  endfunction

  logic [5:0] abcdei;
  logic [3:0] fghj;
  logic [5:0] r6;
  logic [3:0] r4;
  logic       k28_neg;   // 110000, K28 after positive disparity
  logic       is_k;
  logic       bad;

  assign abcdei  = sym[elink_rx_pkg::sym_w-1 -: 6];
  assign k28_neg = (abcdei == 6'b110000);
  assign is_k    = (abcdei == 6'b001111) || k28_neg;
  // K28 in RD+ carries the complemented 4b code
  assign fghj    = k28_neg ? ~sym[3:0] : sym[3:0];
  assign r6      = dec6(abcdei);
  assign r4      = dec4(fghj);
  assign bad     = !r6[5] || !r4[3];

  always_ff @(posedge bit_clk) begin
    if (reset) begin
      wr_en    <= 1'b0;
      code_err <= 1'b0;
    end else begin
      wr_en    <= sym_valid && !sym_comma;         // Idle comma never stored
      code_err <= sym_valid && !sym_comma && bad;
    end
  end

  always_ff @(posedge bit_clk) begin
    if (sym_valid)
      wr_data <= bad ? '0 : {is_k, r4[2:0], r6[4:0]};  // K flag, HGF, EDCBA
  end

endmodule

`default_nettype wire

// File: verilog/rx_fifo.sv
// Receive FIFO
// Circular buffer of decoded words with level count and overflow pulse
`timescale 1ns/1ps
`default_nettype none

module rx_fifo (
  input  wire                               bit_clk,
  input  wire                               reset,
  input  wire                               wr_en,
  input  wire [elink_rx_pkg::word_w-1:0]    wr_data,
  input  wire                               rd_en,
  output logic [elink_rx_pkg::word_w-1:0]   rd_data,
  output logic                              empty,
  output logic [elink_rx_pkg::level_w-1:0]  level,
  output logic                              overflow
);

  logic [elink_rx_pkg::word_w-1:0]  mem [elink_rx_pkg::fifo_depth];
  logic [$clog2(elink_rx_pkg::fifo_depth)-1:0] wr_ptr;  // Wraps at depth
  logic [$clog2(elink_rx_pkg::fifo_depth)-1:0] rd_ptr;
  logic full;
  logic do_rd;
  logic do_wr;

  assign empty = (level == '0);
  assign full  = (level == elink_rx_pkg::level_w'(elink_rx_pkg::fifo_depth));
  assign do_rd = rd_en && !empty;
  assign do_wr = wr_en && (!full || do_rd);  // Pop frees the slot
  assign overflow = wr_en && !do_wr;         // Word lost

  assign rd_data = mem[rd_ptr];  // Head visible without a read

  always_ff @(posedge bit_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        level <= level + 1'b1;
      else if (do_rd && !do_wr)
        level <= level - 1'b1;
    end
  end

  always_ff @(posedge bit_clk) begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

endmodule

`default_nettype wire

// File: verilog/elink_rx_top.sv
// E-link receive top level
// Deserializer, comma aligner, 8b10b decoder, FIFO and APB control
`timescale 1ns/1ps
`default_nettype none

module elink_rx_top (
  input  wire                               bit_clk,
  input  wire                               reset,
  input  wire [1:0]                         rx_bits,
  input  wire                               psel,
  input  wire                               penable,
  input  wire                               pwrite,
  input  wire [elink_rx_pkg::apb_aw-1:0]    paddr,
  input  wire [elink_rx_pkg::apb_dw-1:0]    pwdata,
  output logic [elink_rx_pkg::apb_dw-1:0]   prdata,
  output logic                              pready,
  output logic                              pslverr
);

  logic [elink_rx_pkg::sym_w-1:0]    win_a;
  logic [elink_rx_pkg::sym_w-1:0]    win_b;
  logic [elink_rx_pkg::sym_w-1:0]    sym;
  logic                              sym_valid;
  logic                              sym_comma;
  logic                              aligned;
  logic                              enable;
  logic                              swap_bits;
  logic                              wr_en;
  logic [elink_rx_pkg::word_w-1:0]   wr_data;
  logic                              code_err;
  logic                              rd_en;
  logic [elink_rx_pkg::word_w-1:0]   rd_data;
  logic                              empty;
  logic [elink_rx_pkg::level_w-1:0]  level;
  logic                              overflow;

  elink_rx_ctrl u_ctrl (
    .bit_clk(bit_clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .aligned(aligned), .empty(empty), .level(level), .rd_data(rd_data),
    .code_err(code_err), .overflow(overflow),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .enable(enable), .swap_bits(swap_bits), .rd_en(rd_en)
  );

  elink_deserializer u_deser (
    .bit_clk(bit_clk), .reset(reset), .rx_bits(rx_bits), .swap_bits(swap_bits),
    .win_a(win_a), .win_b(win_b)
  );

  comma_aligner u_align (
    .bit_clk(bit_clk), .reset(reset), .enable(enable), .win_a(win_a), .win_b(win_b),
    .sym(sym), .sym_valid(sym_valid), .sym_comma(sym_comma), .aligned(aligned)
  );

  dec_8b10b u_dec (
    .bit_clk(bit_clk), .reset(reset),
    .sym(sym), .sym_valid(sym_valid), .sym_comma(sym_comma),
    .wr_en(wr_en), .wr_data(wr_data), .code_err(code_err)
  );

  rx_fifo u_fifo (
    .bit_clk(bit_clk), .reset(reset), .wr_en(wr_en), .wr_data(wr_data), .rd_en(rd_en),
    .rd_data(rd_data), .empty(empty), .level(level), .overflow(overflow)
  );

endmodule

`default_nettype wire

// File: tests/elink_rx_properties.sv
// Bound assertions for the E-link receiver
// APB ready, FIFO pop and level rules, comma never stored
`timescale 1ns/1ps
`default_nettype none

module elink_rx_properties (
  input wire                              bit_clk,
  input wire                              reset,
  input wire                              pready,
  input wire                              rd_en,
  input wire                              empty,
  input wire                              wr_en,
  input wire                              sym_valid,
  input wire [elink_rx_pkg::sym_w-1:0]    sym,
  input wire [elink_rx_pkg::level_w-1:0]  level
);

  // No wait states ever
  a_pready: assert property (@(posedge bit_clk) disable iff (reset) pready)
    else $error("pready dropped low");

  a_pop_empty: assert property (@(posedge bit_clk) disable iff (reset) rd_en |-> !empty)
    else $error("FIFO pop while empty");

  a_level: assert property (@(posedge bit_clk) disable iff (reset)
                            level <= elink_rx_pkg::fifo_depth)
    else $error("FIFO level above depth");

  // Idle comma is dropped by the decoder
  a_comma: assert property (@(posedge bit_clk) disable iff (reset)
                            (sym_valid && (sym == elink_rx_pkg::comma_pos ||
                                           sym == elink_rx_pkg::comma_neg)) |=> !wr_en)
    else $error("comma written to FIFO");

endmodule

bind elink_rx_top elink_rx_properties u_props (.*);

`default_nettype wire

// File: tests/tb_elink_rx.sv
// Testbench for the E-link receiver
// File-driven serial stimulus, APB access tasks, checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_elink_rx;

  logic                             bit_clk;
  logic                             reset;
  logic [1:0]                       rx_bits;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [elink_rx_pkg::apb_aw-1:0]  paddr;
  logic [elink_rx_pkg::apb_dw-1:0]  pwdata;
  wire  [elink_rx_pkg::apb_dw-1:0]  prdata;
  wire                              pready;
  wire                              pslverr;

  logic [1:0] bitq[$];     // {is_data, bit}, oldest first
  int         data_left;   // Data bits still queued
  logic       swap_tx;     // Send pairs swapped
  string      tag[$];      // Per-symbol file columns
  logic [9:0] sym_f[$];
  logic       k_f[$];
  logic [7:0] byte_f[$];
  logic       err_f[$];
  int         filler;
  int         cycles;
  int         limit;       // 0 until the file is read
  int         errors;
  int         test_err;
  int         n_pass;
  int         n_fail;

  elink_rx_top uut (.*);

  initial begin
    bit_clk = 1'b0;
    forever #2 bit_clk = ~bit_clk;
  end

  always @(posedge bit_clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, DUT never reached the expected state", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic push_sym(input logic [9:0] s, input logic is_data);
    for (int i = 9; i >= 0; i--) begin
      bitq.push_back({is_data, s[i]});  // Bit a first
    end
    if (is_data)
      data_left += 10;
  endtask

  // Serial driver, idle commas fill any gap
  always @(posedge bit_clk) begin
    logic [1:0] e0;
    logic [1:0] e1;
    #1;
    while (bitq.size() < 2)
      push_sym(elink_rx_pkg::comma_neg, 1'b0);
    e0 = bitq.pop_front();
    e1 = bitq.pop_front();
    data_left -= int'(e0[1]) + int'(e1[1]);
    rx_bits = swap_tx ? {e1[0], e0[0]} : {e0[0], e1[0]};  // Earlier bit in bit 1
  end

  // All APB tasks start and end 1 ns after a rising edge
  task automatic apb_write(input logic [3:0] a, input logic [31:0] d);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = a;
    pwdata = d;
    @(posedge bit_clk);
    #1 penable = 1'b1;
    #2 expect_val("write pready", pready, 1);
    expect_val("write pslverr", pslverr, 0);  // Only CTRL and STATUS are written
    @(posedge bit_clk);
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] a, output logic [31:0] d, output logic e);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = a;
    @(posedge bit_clk);
    #1 penable = 1'b1;
    #2 d = prdata;  // Stable late in the access cycle
    e = pslverr;
    expect_val("read pready", pready, 1);
    @(posedge bit_clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic expect_val(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      test_err++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_err == 0) begin
      $display("PASS  %s", name);
      n_pass++;
    end else begin
      $display("FAIL  %s, %0d mismatches", name, test_err);
      n_fail++;
    end
    errors += test_err;
    test_err = 0;
  endtask

  task automatic wait_aligned();
    logic [31:0] d;
    logic        e;
    d = '0;
    while (!d[0])
      apb_read(elink_rx_pkg::addr_status, d, e);  // Poll aligned bit
  endtask

  // Data fully on the wire, then the 3-cycle pipeline plus one
  task automatic wait_sent();
    while (data_left > 0)
      @(posedge bit_clk);
    repeat (4) @(posedge bit_clk);
    #1;
  endtask

  task automatic send_tag(input string t);
    for (int i = 0; i < tag.size(); i++) begin
      if (tag[i] == t)
        push_sym(sym_f[i], 1'b1);
    end
  endtask

  task automatic read_words(input string t, input int max_n);
    logic [31:0] d;
    logic        e;
    int          n;
    n = 0;
    for (int i = 0; i < tag.size(); i++) begin
      if (tag[i] == t && n < max_n) begin
        apb_read(elink_rx_pkg::addr_data, d, e);
        expect_val("DATA pslverr", e, 0);
        expect_val("DATA word", d, err_f[i] ? 0 : {k_f[i], byte_f[i]});  // Bad code stored as 0
        n++;
      end
    end
  endtask

  task automatic check_status(input int aligned, input int empty, input int err,
                              input int ovf, input int lvl);
    logic [31:0] d;
    logic        e;
    apb_read(elink_rx_pkg::addr_status, d, e);
    expect_val("STATUS aligned", d[0], aligned);
    expect_val("STATUS empty", d[1], empty);
    expect_val("STATUS code_err", d[2], err);
    expect_val("STATUS overflow", d[3], ovf);
    expect_val("STATUS level", d[12:8], lvl);
  endtask

  task automatic run_tests();
    logic [31:0] d;
    logic        e;
    repeat (2) @(posedge bit_clk);
    #1 reset = 1'b0;

    // Reset state, commas on the wire but aligner disabled
    check_status(0, 1, 0, 0, 0);
    apb_read(elink_rx_pkg::addr_data, d, e);
    expect_val("empty DATA value", d, 0);
    expect_val("empty DATA pslverr", e, 1);
    end_test("reset state");

    apb_write(elink_rx_pkg::addr_ctrl, 32'h1);
    wait_aligned();
    send_tag("D");
    wait_sent();
    check_status(1, 0, 0, 0, 5);
    read_words("D", 99);
    check_status(1, 1, 0, 0, 0);
    end_test("odd-phase lock and data");

    send_tag("E");
    wait_sent();
    check_status(1, 0, 1, 0, 3);
    read_words("E", 99);
    apb_write(elink_rx_pkg::addr_status, 32'h4);  // W1C code_err
    check_status(1, 1, 0, 0, 0);
    end_test("code error");

    send_tag("O");
    wait_sent();
    check_status(1, 0, 0, 1, elink_rx_pkg::fifo_depth);
    read_words("O", elink_rx_pkg::fifo_depth);  // Last four were dropped
    apb_write(elink_rx_pkg::addr_status, 32'h8);
    check_status(1, 1, 0, 0, 0);
    end_test("overflow");

    apb_write(elink_rx_pkg::addr_ctrl, 32'h0);  // Drop lock first
    swap_tx = 1'b1;
    apb_write(elink_rx_pkg::addr_ctrl, 32'h3);
    wait_aligned();
    send_tag("S");
    wait_sent();
    read_words("S", 99);
    check_status(1, 1, 0, 0, 0);
    end_test("swapped pairs");

    $display("Tests: %0d passed, %0d failed, %0d mismatches", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  initial begin
    int         fd;
    int         r;
    string      line;
    string      t;
    logic [9:0] s;
    logic       kk;
    logic       ee;
    logic [7:0] bb;
    reset = 1'b1;
    rx_bits = 2'b00;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    swap_tx = 1'b0;
    data_left = 0;
    cycles = 0;
    limit = 0;
    errors = 0;
    test_err = 0;
    n_pass = 0;
    n_fail = 0;
    filler = -1;
    fd = $fopen("tests/elink_rx_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/elink_rx_input.txt");
      $display("Testbench failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        r = $fgets(line, fd);
        if (line.len() < 2 || line[0] == "#")
          continue;  // Blank or column notes
        if (filler < 0) begin
          r = $sscanf(line, "%s %d", t, filler);
        end else begin
          r = $sscanf(line, "%s %b %b %h %b", t, s, kk, bb, ee);
          tag.push_back(t);
          sym_f.push_back(s);
          k_f.push_back(kk);
          byte_f.push_back(bb);
          err_f.push_back(ee);
        end
      end
      $fclose(fd);
      for (int i = 0; i < filler; i++)
        bitq.push_back(2'b00);  // Odd offset, forces win_b phase
      // Five cycles per symbol, two per APB access, margin
      limit = 5 * tag.size() + 2 * (tag.size() + 80) + 200;
      run_tests();
    end
  end

endmodule

`default_nettype wire

// File: tests/elink_rx_input.txt
# tag, symbol abcdei fghj sent left first, K flag, byte hex, error flag
# F line gives the filler bits sent before the first symbol
F 7
D 1001110100 0 00 0
D 0111011001 0 21 0
D 1011010101 0 42 0
D 0011110100 1 1c 0
D 1110001110 0 e7 0
E 1010011010 0 a5 0
E 1111110101 0 00 1
E 0110010110 0 c6 0
O 1001110100 0 00 0
O 0111011001 0 21 0
O 1011010101 0 42 0
O 1100011100 0 63 0
O 1101011101 0 84 0
O 1010011010 0 a5 0
O 0110010110 0 c6 0
O 1110001110 0 e7 0
O 1001110100 0 00 0
O 0111011001 0 21 0
O 1011010101 0 42 0
O 1100011100 0 63 0
O 1101011101 0 84 0
O 1010011010 0 a5 0
O 0110010110 0 c6 0
O 1110001110 0 e7 0
O 0011110100 1 1c 0
O 1001110100 0 00 0
O 0111011001 0 21 0
O 1011010101 0 42 0
S 1100011100 0 63 0
S 1101011101 0 84 0
S 1001110100 0 00 0

// File: compile.f
common/elink_rx_pkg.sv
elink_rx/elink_rx_ctrl.sv
elink_rx/elink_deserializer.sv
elink_rx/comma_aligner.sv
elink_rx/dec_8b10b.sv
verilog/rx_fifo.sv
verilog/elink_rx_top.sv
tests/elink_rx_properties.sv
tests/tb_elink_rx.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_elink_rx
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
